/* all.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/wb_pkg.sv
verilog/scan_if.sv
verilog/scan_timing.sv
verilog/ball_regs.sv
verilog/ball_pixel.sv
verilog/video_out.sv
verilog/ball_display_top.sv
sim/ball_display_sva.sv
sim/tb_ball_display.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ball display testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_ball_display -f all.f -o tb_ball_display > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_ball_display > sim.log 2>&1

grep -qx "No errors" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }

/* sim/ball_display_sva.sv */
`timescale 1ns/1ps

module ball_display_sva (
   input logic            clk,
   input logic            rst_n,
   input logic            wb_cyc,
   input logic            wb_stb,
   input logic            wb_ack,
   input logic            de,
   input logic            hsync,
   input logic            vsync,
   input video_pkg::rgb_t rgb
);

   // **********************************************************************
   // Wishbone handshake
   // **********************************************************************
   ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack stayed high for more than one cycle");

   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      wb_ack |-> (wb_cyc && wb_stb))
      else $error("wb_ack seen without wb_cyc and wb_stb");

   // Video port.
   sync_outside_active: assert property (@(posedge clk) disable iff (!rst_n)
      de |-> (hsync && vsync))
      else $error("sync pulse inside the active area");

   black_in_blanking: assert property (@(posedge clk) disable iff (!rst_n)
      !de |-> (rgb == '0))
      else $error("rgb not black during blanking");

endmodule

bind ball_display_top ball_display_sva sva_i (
   .clk    (clk),
   .rst_n  (rst_n),
   .wb_cyc (wb_cyc),
   .wb_stb (wb_stb),
   .wb_ack (wb_ack),
   .de     (de),
   .hsync  (hsync),
   .vsync  (vsync),
   .rgb    (rgb)
);

/* sim/tb_ball_display.sv */
`timescale 1ns/1ps
`include "ball_display_cfg.svh"

module tb_ball_display;

   typedef enum logic [1:0] {PIX_BALL, PIX_BG, PIX_BLANK} pix_class_e;

   typedef struct packed {
      video_pkg::coord_t bx;
      video_pkg::coord_t by;
      video_pkg::coord_t px;
      video_pkg::coord_t py;
      pix_class_e        cls;
   } probe_t;

   localparam int FRAME_CLKS  = `H_TOTAL * `V_TOTAL;
   localparam int N_CASES     = 15;
   localparam int EXTRA_TESTS = 3; // Register, shadowing and sync sweep.
   localparam int WATCHDOG_NS = (N_CASES + EXTRA_TESTS) * 3 * FRAME_CLKS * 10;
   localparam int HS_FIRST    = `H_ACTIVE + `H_FRONT;
   localparam int HS_LAST     = `H_ACTIVE + `H_FRONT + `H_SYNC - 1;
   localparam int VS_FIRST    = `V_ACTIVE + `V_FRONT;
   localparam int VS_LAST     = `V_ACTIVE + `V_FRONT + `V_SYNC - 1;

   logic              clk;
   logic              rst_n;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   wb_pkg::wb_adr_t   wb_adr;
   wb_pkg::wb_dat_t   wb_dat_w;
   wb_pkg::wb_dat_t   wb_dat_r;
   logic              wb_ack;
   video_pkg::coord_t pix_x;
   video_pkg::coord_t pix_y;
   logic              de;
   logic              hsync;
   logic              vsync;
   video_pkg::rgb_t   rgb;

   string       case_name [N_CASES];
   probe_t      probes [N_CASES];
   int          n_cases;
   int          checks;
   int          errors;
   logic [11:0] ball_col;
   logic [11:0] bg_col;

   ball_display_top dut_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .pix_x    (pix_x),
      .pix_y    (pix_y),
      .de       (de),
      .hsync    (hsync),
      .vsync    (vsync),
      .rgb      (rgb)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests completed");
      $display("Errors found");
      $finish;
   end

   // **********************************************************************
   // Helpers
   // **********************************************************************
   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      checks++;
      assert (exp == act) else begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic bus_access(input logic we, input wb_pkg::wb_adr_t adr,
                             input wb_pkg::wb_dat_t wdata, output wb_pkg::wb_dat_t rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdata;
      do begin
         @(posedge clk);
         #1;
         waited++;
      end while (!wb_ack && waited < 16);
      if (!wb_ack) begin
         $display("Wishbone access to address %0d was never acknowledged", adr);
         errors++;
      end
      rdata = wb_dat_r;
      @(posedge clk); // Strobe stays up through the ack cycle.
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t data);
      wb_pkg::wb_dat_t unused;
      bus_access(1'b1, adr, data, unused);
   endtask

   task automatic read_reg(input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t data);
      bus_access(1'b0, adr, 16'h0000, data);
   endtask

   // Returns once the output shows a given raster position.
   task automatic wait_pixel(input int x, input int y, output logic [11:0] color,
                             output logic de_seen);
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         #1;
         waited++;
      end while (!(pix_x == x && pix_y == y) && waited <= 2 * FRAME_CLKS);
      if (waited > 2 * FRAME_CLKS) begin
         $display("Pixel %0d,%0d never appeared at the video output", x, y);
         errors++;
      end
      color   = rgb;
      de_seen = de;
   endtask

   task automatic wait_frame_start();
      logic [11:0] color;
      logic        de_seen;
      wait_pixel(0, 0, color, de_seen);
   endtask

   function automatic logic [11:0] expected_color(input pix_class_e cls);
      case (cls)
         PIX_BALL: return ball_col;
         PIX_BG:   return bg_col;
         default:  return 12'h000; // Blanking.
      endcase
   endfunction

   task automatic add_case(input string name, input int bx, input int by,
                           input int px, input int py, input pix_class_e cls);
      case_name[n_cases]  = name;
      probes[n_cases].bx  = video_pkg::coord_t'(bx);
      probes[n_cases].by  = video_pkg::coord_t'(by);
      probes[n_cases].px  = video_pkg::coord_t'(px);
      probes[n_cases].py  = video_pkg::coord_t'(py);
      probes[n_cases].cls = cls;
      n_cases++;
   endtask

   // **********************************************************************
   // Tests
   // **********************************************************************
   task automatic run_register_test();
      wb_pkg::wb_dat_t rd;
      wb_pkg::wb_dat_t f0;
      write_reg(wb_pkg::REG_BALL_COLOR, {4'h0, ball_col});
      write_reg(wb_pkg::REG_BG_COLOR, {4'h0, bg_col});
      read_reg(wb_pkg::REG_BALL_COLOR, rd);
      check_value("ball_color_readback", {4'h0, ball_col}, rd);
      read_reg(wb_pkg::REG_BG_COLOR, rd);
      check_value("bg_color_readback", {4'h0, bg_col}, rd);
      write_reg(3'd5, 16'hBEEF);
      read_reg(3'd5, rd);
      check_value("unmapped_read", 16'h0000, rd);
      wait_frame_start(); // Reads sit well away from a frame boundary.
      read_reg(wb_pkg::REG_FRAME, f0);
      wait_frame_start();
      read_reg(wb_pkg::REG_FRAME, rd);
      check_value("frame_count_step", 16'(f0 + 1), rd);
   endtask

   task automatic run_shadow_test();
      logic [11:0] got;
      logic        got_de;
      write_reg(wb_pkg::REG_BALL_X, 16'd80);
      write_reg(wb_pkg::REG_BALL_Y, 16'd60);
      wait_frame_start();
      wait_pixel(0, 10, got, got_de);
      write_reg(wb_pkg::REG_BALL_X, 16'd30); // Mid-frame move.
      write_reg(wb_pkg::REG_BALL_Y, 16'd90);
      wait_pixel(80, 60, got, got_de);
      check_value("shadow_old_pos_same_frame", {4'h0, ball_col}, {4'h0, got});
      wait_pixel(30, 90, got, got_de);
      check_value("shadow_new_pos_same_frame", {4'h0, bg_col}, {4'h0, got});
      wait_pixel(80, 60, got, got_de);
      check_value("shadow_old_pos_next_frame", {4'h0, bg_col}, {4'h0, got});
      wait_pixel(30, 90, got, got_de);
      check_value("shadow_new_pos_next_frame", {4'h0, ball_col}, {4'h0, got});
   endtask

   task automatic run_sync_sweep();
      int   bad;
      int   x;
      int   y;
      logic exp_hs;
      logic exp_vs;
      logic exp_de;
      bad = 0;
      wait_frame_start();
      for (int n = 1; n <= FRAME_CLKS; n++) begin
         @(posedge clk);
         #1;
         x      = n % `H_TOTAL; // Pixels counted from the frame start.
         y      = (n / `H_TOTAL) % `V_TOTAL;
         exp_hs = !(x >= HS_FIRST && x <= HS_LAST);
         exp_vs = !(y >= VS_FIRST && y <= VS_LAST);
         exp_de = (x < `H_ACTIVE) && (y < `V_ACTIVE);
         if (pix_x != x || pix_y != y) bad++;
         if (hsync != exp_hs || vsync != exp_vs || de != exp_de) bad++;
         if (!de && rgb != 12'h000) bad++;
      end
      check_value("sync_and_blank_sweep", 16'd0, 16'(bad));
   endtask

   initial begin
      logic [11:0] got;
      logic        got_de;
      n_cases  = 0;
      checks   = 0;
      errors   = 0;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      void'($urandom(32'h62a6));
      do begin
         ball_col = 12'($urandom);
         bg_col   = 12'($urandom);
      end while (ball_col == bg_col || ball_col == 12'h000 || bg_col == 12'h000);

      add_case("centre",          80,  60,  80,  60, PIX_BALL);
      add_case("interior_ne",     80,  60,  88,  52, PIX_BALL);
      add_case("interior_nw",     80,  60,  72,  52, PIX_BALL);
      add_case("interior_se",     80,  60,  88,  68, PIX_BALL);
      add_case("interior_sw",     80,  60,  72,  68, PIX_BALL);
      add_case("corner_tl",       80,  60,  64,  44, PIX_BG);
      add_case("corner_tr",       80,  60,  95,  44, PIX_BG);
      add_case("corner_bl",       80,  60,  64,  75, PIX_BG);
      add_case("corner_br",       80,  60,  95,  75, PIX_BG);
      add_case("outside_right",   80,  60,  96,  60, PIX_BG);
      add_case("outside_top",     80,  60,  80,  43, PIX_BG);
      add_case("clip_origin",      4,   4,   0,   0, PIX_BALL);
      add_case("clip_far_corner",  4,   4, 159, 119, PIX_BG);
      add_case("blank_right",    150,  60, 165,  60, PIX_BLANK);
      add_case("blank_bottom",    80, 110,  80, 121, PIX_BLANK);

      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      run_register_test();
      for (int i = 0; i < n_cases; i++) begin
         write_reg(wb_pkg::REG_BALL_X, 16'(probes[i].bx));
         write_reg(wb_pkg::REG_BALL_Y, 16'(probes[i].by));
         wait_frame_start(); // New position is live from here.
         wait_pixel(probes[i].px, probes[i].py, got, got_de);
         check_value({case_name[i], "_de"}, 16'(probes[i].cls != PIX_BLANK), 16'(got_de));
         check_value(case_name[i], {4'h0, expected_color(probes[i].cls)}, {4'h0, got});
      end
      run_shadow_test();
      run_sync_sweep();

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* verilog/ball_display_cfg.svh */
`ifndef BALL_DISPLAY_CFG_SVH
`define BALL_DISPLAY_CFG_SVH

// **********************************************************************
// Reduced raster timing, in pixels per line
// **********************************************************************
`define H_ACTIVE 160
`define H_FRONT  8
`define H_SYNC   16
`define H_BACK   16
`define H_TOTAL  200

// Lines per frame.
`define V_ACTIVE 120
`define V_FRONT  2
`define V_SYNC   3
`define V_BACK   5
`define V_TOTAL  130

// **********************************************************************
// Sprite box
// **********************************************************************
`define BALL_SIZE 32 // Edge of the ROM bitmap.
`define BALL_HALF 16

`endif

/* verilog/ball_display_top.sv */
`timescale 1ns/1ps

module ball_display_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wb_cyc,
   input  logic              wb_stb,
   input  logic              wb_we,
   input  wb_pkg::wb_adr_t   wb_adr,
   input  wb_pkg::wb_dat_t   wb_dat_w,
   output wb_pkg::wb_dat_t   wb_dat_r,
   output logic              wb_ack,
   output video_pkg::coord_t pix_x,
   output video_pkg::coord_t pix_y,
   output logic              de,
   output logic              hsync,
   output logic              vsync,
   output video_pkg::rgb_t   rgb
);

   video_pkg::coord_t ball_x;
   video_pkg::coord_t ball_y;
   video_pkg::rgb_t   ball_color;
   video_pkg::rgb_t   bg_color;
   logic              on_ball;

   scan_if scan ();

   scan_timing u_scan_timing (
      .clk   (clk),
      .rst_n (rst_n),
      .scan  (scan.src)
   );

   ball_regs u_ball_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .frame_start (scan.frame_start),
      .ball_x      (ball_x),
      .ball_y      (ball_y),
      .ball_color  (ball_color),
      .bg_color    (bg_color)
   );

   ball_pixel u_ball_pixel (
      .ball_x  (ball_x),
      .ball_y  (ball_y),
      .scan    (scan.sink_pixel),
      .on_ball (on_ball)
   );

   video_out u_video_out (
      .clk        (clk),
      .rst_n      (rst_n),
      .scan       (scan.sink_out),
      .on_ball    (on_ball),
      .ball_color (ball_color),
      .bg_color   (bg_color),
      .pix_x      (pix_x),
      .pix_y      (pix_y),
      .de         (de),
      .hsync      (hsync),
      .vsync      (vsync),
      .rgb        (rgb)
   );

endmodule

/* verilog/ball_pixel.sv */
`timescale 1ns/1ps
`include "ball_display_cfg.svh"

module ball_pixel (
   input  video_pkg::coord_t ball_x,
   input  video_pkg::coord_t ball_y,
   scan_if.sink_pixel        scan,
   output logic              on_ball
);

   // Offsets into the sprite box, one bit wider than a coordinate.
   logic [11:0] dx;
   logic [11:0] dy;
   logic        in_box;
   logic [4:0]  col;
   logic [4:0]  row;
   logic [3:0]  rom_addr;
   logic [31:0] rom_word;

   // Wraps far outside the box, so the compare clips at the screen edges.
   assign dx = {1'b0, scan.h_count} - {1'b0, ball_x} + 12'(`BALL_HALF);
   assign dy = {1'b0, scan.v_count} - {1'b0, ball_y} + 12'(`BALL_HALF);

   assign in_box = (dx < 12'(`BALL_SIZE)) && (dy < 12'(`BALL_SIZE));

   assign col = dx[4:0];
   assign row = dy[4:0];

   // Lower half mirrors the upper half.
   assign rom_addr = row[4] ? ~row[3:0] : row[3:0];

   // **********************************************************************
   // Round bitmap, top half
   // **********************************************************************
   always_comb begin
      case (rom_addr)
         4'h0:    rom_word = 32'h000F_F000;
         4'h1:    rom_word = 32'h007F_FE00;
         4'h2:    rom_word = 32'h00FF_FF00;
         4'h3:    rom_word = 32'h03FF_FFC0;
         4'h4:    rom_word = 32'h07FF_FFE0;
         4'h5:    rom_word = 32'h0FFF_FFF0;
         4'h6:    rom_word = 32'h1FFF_FFF8;
         4'h7:    rom_word = 32'h1FFF_FFF8;
         4'h8:    rom_word = 32'h3FFF_FFFC;
         4'h9:    rom_word = 32'h7FFF_FFFE;
         4'hA:    rom_word = 32'h7FFF_FFFE;
         4'hB:    rom_word = 32'h7FFF_FFFE;
         default: rom_word = 32'hFFFF_FFFF; // Widest rows.
      endcase
   end

   assign on_ball = in_box && rom_word[col];

endmodule

/* verilog/ball_regs.sv */
`timescale 1ns/1ps
`include "ball_display_cfg.svh"

module ball_regs (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               wb_cyc,
   input  logic               wb_stb,
   input  logic               wb_we,
   input  wb_pkg::wb_adr_t    wb_adr,
   input  wb_pkg::wb_dat_t    wb_dat_w,
   output wb_pkg::wb_dat_t    wb_dat_r,
   output logic               wb_ack,
   input  logic               frame_start,
   output video_pkg::coord_t  ball_x,
   output video_pkg::coord_t  ball_y,
   output video_pkg::rgb_t    ball_color,
   output video_pkg::rgb_t    bg_color
);

   localparam video_pkg::coord_t X_HOME = video_pkg::coord_t'(`H_ACTIVE / 2);
   localparam video_pkg::coord_t Y_HOME = video_pkg::coord_t'(`V_ACTIVE / 2);

   wb_pkg::wb_state_e  state;
   video_pkg::coord_t  shadow_x;
   video_pkg::coord_t  shadow_y;
   wb_pkg::wb_dat_t    frame_cnt;
   wb_pkg::wb_dat_t    rd_data;
   wb_pkg::reg_addr_e  addr;
   logic               wr_en;

   assign addr  = wb_pkg::reg_addr_e'(wb_adr);
   assign wr_en = (state == wb_pkg::WB_ACK) && wb_we;

   // **********************************************************************
   // Bus FSM
   // **********************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state  <= wb_pkg::WB_IDLE;
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= 1'b0;
         case (state)
            wb_pkg::WB_IDLE: begin
               if (wb_cyc && wb_stb && !wb_ack) begin // Skip the ack cycle.
                  state <= wb_pkg::WB_ACK;
               end
            end
            default: begin
               state  <= wb_pkg::WB_IDLE;
               wb_ack <= 1'b1;
            end
         endcase
      end
   end

   always_comb begin
      case (addr)
         wb_pkg::REG_BALL_X:     rd_data = {5'd0, shadow_x};
         wb_pkg::REG_BALL_Y:     rd_data = {5'd0, shadow_y};
         wb_pkg::REG_BALL_COLOR: rd_data = {4'd0, ball_color};
         wb_pkg::REG_BG_COLOR:   rd_data = {4'd0, bg_color};
         wb_pkg::REG_FRAME:      rd_data = frame_cnt;
         default:                rd_data = '0; // Unmapped.
      endcase
   end

   always_ff @(posedge clk) begin
      if (state == wb_pkg::WB_ACK) begin
         wb_dat_r <= rd_data; // Valid with ack.
      end
   end

   // **********************************************************************
   // Registers
   // **********************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         shadow_x   <= X_HOME;
         shadow_y   <= Y_HOME;
         ball_x     <= X_HOME;
         ball_y     <= Y_HOME;
         ball_color <= video_pkg::RGB_BLACK;
         bg_color   <= video_pkg::RGB_BLACK;
         frame_cnt  <= '0;
      end else begin
         if (wr_en) begin
            case (addr)
               wb_pkg::REG_BALL_X:     shadow_x   <= wb_dat_w[10:0];
               wb_pkg::REG_BALL_Y:     shadow_y   <= wb_dat_w[10:0];
               wb_pkg::REG_BALL_COLOR: ball_color <= video_pkg::rgb_t'(wb_dat_w[11:0]);
               wb_pkg::REG_BG_COLOR:   bg_color   <= video_pkg::rgb_t'(wb_dat_w[11:0]);
               default: ;
            endcase
         end
         if (frame_start) begin
            ball_x    <= shadow_x; // Position fixed for the whole frame.
            ball_y    <= shadow_y;
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

endmodule

/* verilog/scan_if.sv */
`timescale 1ns/1ps

interface scan_if;

   video_pkg::coord_t h_count;
   video_pkg::coord_t v_count;
   logic              active;      // Inside the visible area.
   logic              hsync;       // Active low.
   logic              vsync;       // Active low.
   logic              frame_start; // First pixel of a frame.

   modport src (
      output h_count, v_count, active, hsync, vsync, frame_start
   );

   modport sink_pixel (
      input h_count, v_count
   );

   modport sink_out (
      input h_count, v_count, active, hsync, vsync, frame_start
   );

endinterface

/* verilog/scan_timing.sv */
`timescale 1ns/1ps
`include "ball_display_cfg.svh"

module scan_timing (
   input  logic clk,
   input  logic rst_n,
   scan_if.src  scan
);

   // **********************************************************************
   // Raster limits as coordinates
   // **********************************************************************
   localparam video_pkg::coord_t H_LAST =
      video_pkg::coord_t'(`H_TOTAL - 1);
   localparam video_pkg::coord_t V_LAST =
      video_pkg::coord_t'(`V_TOTAL - 1);
   localparam video_pkg::coord_t H_VIS =
      video_pkg::coord_t'(`H_ACTIVE);
   localparam video_pkg::coord_t V_VIS =
      video_pkg::coord_t'(`V_ACTIVE);
   localparam video_pkg::coord_t HS_FIRST =
      video_pkg::coord_t'(`H_ACTIVE + `H_FRONT);
   localparam video_pkg::coord_t HS_LAST =
      video_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1);
   localparam video_pkg::coord_t VS_FIRST =
      video_pkg::coord_t'(`V_ACTIVE + `V_FRONT);
   localparam video_pkg::coord_t VS_LAST =
      video_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);

   video_pkg::coord_t h_cnt;
   video_pkg::coord_t v_cnt;
   logic              line_end;

   assign line_end = (h_cnt == H_LAST);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (line_end) begin
            h_cnt <= '0;
            if (v_cnt == V_LAST) begin
               v_cnt <= '0; // Wrap to the next frame.
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // **********************************************************************
   // Decoded timing
   // **********************************************************************
   assign scan.h_count     = h_cnt;
   assign scan.v_count     = v_cnt;
   assign scan.active      = (h_cnt < H_VIS) && (v_cnt < V_VIS);
   assign scan.hsync       = !((h_cnt >= HS_FIRST) && (h_cnt <= HS_LAST));
   assign scan.vsync       = !((v_cnt >= VS_FIRST) && (v_cnt <= VS_LAST));
   assign scan.frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

/* verilog/video_out.sv */
`timescale 1ns/1ps

module video_out (
   input  logic              clk,
   input  logic              rst_n,
   scan_if.sink_out          scan,
   input  logic              on_ball,
   input  video_pkg::rgb_t   ball_color,
   input  video_pkg::rgb_t   bg_color,
   output video_pkg::coord_t pix_x,
   output video_pkg::coord_t pix_y,
   output logic              de,
   output logic              hsync,
   output logic              vsync,
   output video_pkg::rgb_t   rgb
);

   video_pkg::rgb_t pix_color;

   always_comb begin
      if (!scan.active) begin
         pix_color = video_pkg::RGB_BLACK; // Blanking.
      end else if (on_ball) begin
         pix_color = ball_color;
      end else begin
         pix_color = bg_color;
      end
   end

   // **********************************************************************
   // Output register, one cycle behind the scan
   // **********************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pix_x <= '0;
         pix_y <= '0;
         de    <= 1'b0;
         hsync <= 1'b1;
         vsync <= 1'b1;
         rgb   <= video_pkg::RGB_BLACK;
      end else begin
         pix_x <= scan.h_count;
         pix_y <= scan.v_count;
         de    <= scan.active;
         hsync <= scan.hsync;
         vsync <= scan.vsync;
         rgb   <= pix_color;
      end
   end

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

   // Pixel or line coordinate over the whole raster.
   typedef logic [10:0] coord_t;

   // 4:4:4 colour, red in the top nibble.
   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   localparam rgb_t RGB_BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

/* verilog/wb_pkg.sv */
package wb_pkg;

   typedef logic [2:0]  wb_adr_t; // Word address.
   typedef logic [15:0] wb_dat_t;

   // Register map.
   typedef enum logic [2:0] {
      REG_BALL_X     = 3'd0, // Shadow, loads at frame start.
      REG_BALL_Y     = 3'd1, // Shadow, loads at frame start.
      REG_BALL_COLOR = 3'd2,
      REG_BG_COLOR   = 3'd3,
      REG_FRAME      = 3'd4  // Read only.
   } reg_addr_e;

   // Slave FSM.
   typedef enum logic {
      WB_IDLE = 1'b0,
      WB_ACK  = 1'b1
   } wb_state_e;

endpackage
